// ==== hdl/wb_soc_pkg.sv ====
`default_nettype none

package wb_soc_pkg;

    // Bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 30;
    localparam int SEL_W  = 4;

    // Word RAM depth is 2**RAM_AW words
    localparam int RAM_AW = 10;

    // LED and switch vectors
    localparam int IO_W = 16;

    typedef logic [DATA_W-1:0] wb_data_t;
    typedef logic [ADDR_W-1:0] wb_addr_t;
    typedef logic [SEL_W-1:0]  wb_sel_t;
    typedef logic [IO_W-1:0]   io_vec_t;

    // Memory map, all word addresses
    // RAM sits wherever the bits above RAM_AW are zero
    localparam wb_addr_t SWLED_ADDR = 30'h0400001;
    // Timer count at TIMER_BASE, limit at TIMER_BASE + 1
    localparam wb_addr_t TIMER_BASE = 30'h3FFFFFFC;

    // Current bus owner in the arbiter
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_A,
        OWN_B
    } arb_owner_t;

endpackage : wb_soc_pkg

`default_nettype wire

// ==== hdl/wb_pri_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_pri_arbiter (
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    // Master A, data port, higher priority
    input  wire                   i_a_cyc,
    input  wire                   i_a_stb,
    input  wire                   i_a_we,
    input  wire wb_soc_pkg::wb_addr_t i_a_addr,
    input  wire wb_soc_pkg::wb_data_t i_a_data,
    input  wire wb_soc_pkg::wb_sel_t  i_a_sel,
    output logic                  o_a_stall,
    output logic                  o_a_ack,
    output logic                  o_a_err,
    output wb_soc_pkg::wb_data_t  o_a_rdata,
    // Master B, instruction port
    input  wire                   i_b_cyc,
    input  wire                   i_b_stb,
    input  wire                   i_b_we,
    input  wire wb_soc_pkg::wb_addr_t i_b_addr,
    input  wire wb_soc_pkg::wb_data_t i_b_data,
    input  wire wb_soc_pkg::wb_sel_t  i_b_sel,
    output logic                  o_b_stall,
    output logic                  o_b_ack,
    output logic                  o_b_err,
    output wb_soc_pkg::wb_data_t  o_b_rdata,
    // Merged bus
    output logic                  o_cyc,
    output logic                  o_stb,
    output logic                  o_we,
    output wb_soc_pkg::wb_addr_t  o_addr,
    output wb_soc_pkg::wb_data_t  o_data,
    output wb_soc_pkg::wb_sel_t   o_sel,
    input  wire                   i_ack,
    input  wire                   i_err,
    input  wire wb_soc_pkg::wb_data_t i_rdata
);

    wb_soc_pkg::arb_owner_t owner_q;
    wb_soc_pkg::arb_owner_t owner_d;
    logic own_a;
    logic own_b;

    // A wins a tie; the owner holds the bus until its cyc drops
    always_comb begin
        owner_d = owner_q;
        case (owner_q)
            wb_soc_pkg::OWN_NONE: begin
                if (i_a_cyc) begin
                    owner_d = wb_soc_pkg::OWN_A;
                end else if (i_b_cyc) begin
                    owner_d = wb_soc_pkg::OWN_B;
                end
            end
            wb_soc_pkg::OWN_A: begin
                if (!i_a_cyc) begin
                    owner_d = wb_soc_pkg::OWN_NONE;
                end
            end
            wb_soc_pkg::OWN_B: begin
                if (!i_b_cyc) begin
                    owner_d = wb_soc_pkg::OWN_NONE;
                end
            end
            default: owner_d = wb_soc_pkg::OWN_NONE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            owner_q <= wb_soc_pkg::OWN_NONE;
        end else begin
            owner_q <= owner_d;
        end
    end

    assign own_a = (owner_q == wb_soc_pkg::OWN_A);
    assign own_b = (owner_q == wb_soc_pkg::OWN_B);

    // Request steering, stb stays low with no owner
    assign o_cyc  = (own_a && i_a_cyc) || (own_b && i_b_cyc);
    assign o_stb  = (own_a && i_a_cyc && i_a_stb) || (own_b && i_b_cyc && i_b_stb);
    assign o_we   = own_b ? i_b_we   : i_a_we;
    assign o_addr = own_b ? i_b_addr : i_a_addr;
    assign o_data = own_b ? i_b_data : i_a_data;
    assign o_sel  = own_b ? i_b_sel  : i_a_sel;

    // Responses only reach the owner
    assign o_a_stall = !own_a;
    assign o_a_ack   = own_a && i_ack;
    assign o_a_err   = own_a && i_err;
    assign o_a_rdata = own_a ? i_rdata : '0;

    assign o_b_stall = !own_b;
    assign o_b_ack   = own_b && i_ack;
    assign o_b_err   = own_b && i_err;
    assign o_b_rdata = own_b ? i_rdata : '0;

endmodule : wb_pri_arbiter

`default_nettype wire

// ==== hdl/wb_addr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_addr_decode (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_cyc,
    input  wire                       i_stb,
    input  wire wb_soc_pkg::wb_addr_t i_addr,
    // Slave strobes
    output logic                      o_ram_stb,
    output logic                      o_swled_stb,
    output logic                      o_timer_stb,
    // Slave responses
    input  wire                       i_ram_ack,
    input  wire                       i_swled_ack,
    input  wire                       i_timer_ack,
    input  wire wb_soc_pkg::wb_data_t i_ram_rdata,
    input  wire wb_soc_pkg::wb_data_t i_swled_rdata,
    input  wire wb_soc_pkg::wb_data_t i_timer_rdata,
    // Merged response
    output logic                      o_ack,
    output logic                      o_err,
    output wb_soc_pkg::wb_data_t      o_rdata
);

    localparam int HI_W = wb_soc_pkg::ADDR_W - wb_soc_pkg::RAM_AW;

    logic ram_match;
    logic swled_match;
    logic timer_match;
    logic none_match;
    logic req;
    logic err_req;
    logic err_q;
    logic any_ack;
    wb_soc_pkg::wb_data_t rdata_mux;

    // Memory map
    assign ram_match   = (i_addr[wb_soc_pkg::ADDR_W-1:wb_soc_pkg::RAM_AW] == HI_W'(0));
    assign swled_match = (i_addr == wb_soc_pkg::SWLED_ADDR);
    // Timer covers a pair of words
    assign timer_match = (i_addr[wb_soc_pkg::ADDR_W-1:1]
                          == wb_soc_pkg::TIMER_BASE[wb_soc_pkg::ADDR_W-1:1]);
    assign none_match  = !(ram_match || swled_match || timer_match);

    assign req = i_cyc && i_stb;

    assign o_ram_stb   = req && ram_match;
    assign o_swled_stb = req && swled_match;
    assign o_timer_stb = req && timer_match;

    assign err_req = req && none_match;

    assign any_ack = i_ram_ack || i_swled_ack || i_timer_ack;

    // At most one slave acks in a cycle
    always_comb begin
        if (i_ram_ack) begin
            rdata_mux = i_ram_rdata;
        end else if (i_swled_ack) begin
            rdata_mux = i_swled_rdata;
        end else if (i_timer_ack) begin
            rdata_mux = i_timer_rdata;
        end else begin
            rdata_mux = '0;
        end
    end

    // Response flops, dropped when the cycle is abandoned
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || !i_cyc) begin
            o_ack <= 1'b0;
            err_q <= 1'b0;
            o_err <= 1'b0;
        end else begin
            o_ack <= any_ack;
            // Two stages so err matches the slave ack latency
            err_q <= err_req;
            o_err <= err_q;
        end
    end

    always_ff @(posedge i_clk) begin
        o_rdata <= rdata_mux;
    end

endmodule : wb_addr_decode

`default_nettype wire

// ==== hdl/wb_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_ram (
    input  wire                       i_clk,
    input  wire                       i_stb,
    input  wire                       i_we,
    input  wire [wb_soc_pkg::RAM_AW-1:0] i_addr,
    input  wire wb_soc_pkg::wb_data_t i_data,
    input  wire wb_soc_pkg::wb_sel_t  i_sel,
    output logic                      o_ack,
    output wb_soc_pkg::wb_data_t      o_rdata
);

    localparam int DEPTH = 2 ** wb_soc_pkg::RAM_AW;

    wb_soc_pkg::wb_data_t mem [DEPTH];

    // Byte lane writes
    always_ff @(posedge i_clk) begin
        if (i_stb && i_we) begin
            for (int b = 0; b < wb_soc_pkg::SEL_W; b++) begin
                if (i_sel[b]) begin
                    mem[i_addr][b*8 +: 8] <= i_data[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, old data on a write
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_rdata <= mem[i_addr];
        end
    end

    // Never stalls, ack follows stb by one cycle
    always_ff @(posedge i_clk) begin
        o_ack <= i_stb;
    end

endmodule : wb_ram

`default_nettype wire

// ==== hdl/wb_switch_led.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_switch_led (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_stb,
    input  wire                       i_we,
    input  wire wb_soc_pkg::wb_data_t i_data,
    input  wire wb_soc_pkg::wb_sel_t  i_sel,
    input  wire wb_soc_pkg::io_vec_t  i_switches,
    output logic                      o_ack,
    output wb_soc_pkg::wb_data_t      o_rdata,
    output wb_soc_pkg::io_vec_t       o_leds
);

    // LED register, one byte per sel bit
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_leds <= '0;
        end else if (i_stb && i_we) begin
            if (i_sel[0]) begin
                o_leds[7:0] <= i_data[7:0];
            end
            if (i_sel[1]) begin
                o_leds[15:8] <= i_data[15:8];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;
        end
    end

    // LEDs on top, switches below
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_rdata <= {o_leds, i_switches};
        end
    end

endmodule : wb_switch_led

`default_nettype wire

// ==== hdl/wb_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_timer (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_stb,
    input  wire                       i_we,
    input  wire                       i_reg,
    input  wire wb_soc_pkg::wb_data_t i_data,
    output logic                      o_ack,
    output wb_soc_pkg::wb_data_t      o_rdata
);

    wb_soc_pkg::wb_data_t count;
    wb_soc_pkg::wb_data_t limit;
    logic wr_count;
    logic wr_limit;

    assign wr_count = i_stb && i_we && !i_reg;
    assign wr_limit = i_stb && i_we && i_reg;

    // Free running, wraps to zero once it reaches the limit
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            count <= '0;
        end else if (wr_count) begin
            count <= i_data;
        end else if (count == limit) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            limit <= '1;
        end else if (wr_limit) begin
            limit <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;
        end
    end

    // Word 0 is the count, word 1 the limit
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_rdata <= i_reg ? limit : count;
        end
    end

endmodule : wb_timer

`default_nettype wire

// ==== hdl/wb_soc_fabric.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_soc_fabric (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    // Master A
    input  wire                       i_a_cyc,
    input  wire                       i_a_stb,
    input  wire                       i_a_we,
    input  wire wb_soc_pkg::wb_addr_t i_a_addr,
    input  wire wb_soc_pkg::wb_data_t i_a_data,
    input  wire wb_soc_pkg::wb_sel_t  i_a_sel,
    output logic                      o_a_stall,
    output logic                      o_a_ack,
    output logic                      o_a_err,
    output wb_soc_pkg::wb_data_t      o_a_rdata,
    // Master B
    input  wire                       i_b_cyc,
    input  wire                       i_b_stb,
    input  wire                       i_b_we,
    input  wire wb_soc_pkg::wb_addr_t i_b_addr,
    input  wire wb_soc_pkg::wb_data_t i_b_data,
    input  wire wb_soc_pkg::wb_sel_t  i_b_sel,
    output logic                      o_b_stall,
    output logic                      o_b_ack,
    output logic                      o_b_err,
    output wb_soc_pkg::wb_data_t      o_b_rdata,
    // Board IO
    output wb_soc_pkg::io_vec_t       o_leds,
    input  wire wb_soc_pkg::io_vec_t  i_switches
);

    // Merged bus after arbitration
    logic                 bus_cyc;
    logic                 bus_stb;
    logic                 bus_we;
    wb_soc_pkg::wb_addr_t bus_addr;
    wb_soc_pkg::wb_data_t bus_data;
    wb_soc_pkg::wb_sel_t  bus_sel;
    logic                 bus_ack;
    logic                 bus_err;
    wb_soc_pkg::wb_data_t bus_rdata;

    // Per slave strobes and responses
    logic                 ram_stb;
    logic                 swled_stb;
    logic                 timer_stb;
    logic                 ram_ack;
    logic                 swled_ack;
    logic                 timer_ack;
    wb_soc_pkg::wb_data_t ram_rdata;
    wb_soc_pkg::wb_data_t swled_rdata;
    wb_soc_pkg::wb_data_t timer_rdata;

    wb_pri_arbiter arbiter_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_a_cyc   (i_a_cyc),
        .i_a_stb   (i_a_stb),
        .i_a_we    (i_a_we),
        .i_a_addr  (i_a_addr),
        .i_a_data  (i_a_data),
        .i_a_sel   (i_a_sel),
        .o_a_stall (o_a_stall),
        .o_a_ack   (o_a_ack),
        .o_a_err   (o_a_err),
        .o_a_rdata (o_a_rdata),
        .i_b_cyc   (i_b_cyc),
        .i_b_stb   (i_b_stb),
        .i_b_we    (i_b_we),
        .i_b_addr  (i_b_addr),
        .i_b_data  (i_b_data),
        .i_b_sel   (i_b_sel),
        .o_b_stall (o_b_stall),
        .o_b_ack   (o_b_ack),
        .o_b_err   (o_b_err),
        .o_b_rdata (o_b_rdata),
        .o_cyc     (bus_cyc),
        .o_stb     (bus_stb),
        .o_we      (bus_we),
        .o_addr    (bus_addr),
        .o_data    (bus_data),
        .o_sel     (bus_sel),
        .i_ack     (bus_ack),
        .i_err     (bus_err),
        .i_rdata   (bus_rdata)
    );

    wb_addr_decode decode_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_cyc         (bus_cyc),
        .i_stb         (bus_stb),
        .i_addr        (bus_addr),
        .o_ram_stb     (ram_stb),
        .o_swled_stb   (swled_stb),
        .o_timer_stb   (timer_stb),
        .i_ram_ack     (ram_ack),
        .i_swled_ack   (swled_ack),
        .i_timer_ack   (timer_ack),
        .i_ram_rdata   (ram_rdata),
        .i_swled_rdata (swled_rdata),
        .i_timer_rdata (timer_rdata),
        .o_ack         (bus_ack),
        .o_err         (bus_err),
        .o_rdata       (bus_rdata)
    );

    wb_ram ram_i (
        .i_clk   (i_clk),
        .i_stb   (ram_stb),
        .i_we    (bus_we),
        .i_addr  (bus_addr[wb_soc_pkg::RAM_AW-1:0]),
        .i_data  (bus_data),
        .i_sel   (bus_sel),
        .o_ack   (ram_ack),
        .o_rdata (ram_rdata)
    );

    wb_switch_led swled_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stb      (swled_stb),
        .i_we       (bus_we),
        .i_data     (bus_data),
        .i_sel      (bus_sel),
        .i_switches (i_switches),
        .o_ack      (swled_ack),
        .o_rdata    (swled_rdata),
        .o_leds     (o_leds)
    );

    // Lowest address bit picks count or limit
    wb_timer timer_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_stb   (timer_stb),
        .i_we    (bus_we),
        .i_reg   (bus_addr[0]),
        .i_data  (bus_data),
        .o_ack   (timer_ack),
        .o_rdata (timer_rdata)
    );

endmodule : wb_soc_fabric

`default_nettype wire

// ==== verif/tb_wb_soc_tasks.svh ====
`ifndef TB_WB_SOC_TASKS_SVH
`define TB_WB_SOC_TASKS_SVH

task automatic fail_now(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
endtask

task automatic check_data(input string name, input wb_soc_pkg::wb_data_t got,
                          input wb_soc_pkg::wb_data_t exp);
    if (got !== exp) begin
        fail_now($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_io(input string name, input wb_soc_pkg::io_vec_t got,
                        input wb_soc_pkg::io_vec_t exp);
    if (got !== exp) begin
        fail_now($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_now($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

// Selected bytes of the new word replace those of the old word
function automatic wb_soc_pkg::wb_data_t merge_bytes(input wb_soc_pkg::wb_data_t old_w,
                                                     input wb_soc_pkg::wb_data_t new_w,
                                                     input wb_soc_pkg::wb_sel_t sel);
    wb_soc_pkg::wb_data_t res;
    res = old_w;
    for (int b = 0; b < wb_soc_pkg::SEL_W; b++) begin
        if (sel[b]) begin
            res[b*8 +: 8] = new_w[b*8 +: 8];
        end
    end
    return res;
endfunction

task automatic drive_master(input int m, input logic cyc, input logic stb, input logic we,
                            input wb_soc_pkg::wb_addr_t addr,
                            input wb_soc_pkg::wb_data_t data,
                            input wb_soc_pkg::wb_sel_t sel);
    if (m == 0) begin
        a_cyc = cyc;
        a_stb = stb;
        a_we = we;
        a_addr = addr;
        a_data = data;
        a_sel = sel;
    end else begin
        b_cyc = cyc;
        b_stb = stb;
        b_we = we;
        b_addr = addr;
        b_data = data;
        b_sel = sel;
    end
endtask

task automatic sample_rsp(input int m, output logic stall, output logic ack, output logic err,
                          output wb_soc_pkg::wb_data_t rdata);
    stall = (m == 0) ? a_stall : b_stall;
    ack = (m == 0) ? a_ack : b_ack;
    err = (m == 0) ? a_err : b_err;
    rdata = (m == 0) ? a_rdata : b_rdata;
endtask

// Pipelined cycle of n requests from the request list of master m
task automatic run_bus(input int m, input int n);
    int issued;
    int done;
    int stall_run;
    logic accept;
    logic stall;
    logic ack;
    logic err;
    wb_soc_pkg::wb_data_t rdata;
    issued = 0;
    done = 0;
    stall_run = 0;
    @(posedge clk);
    #1;
    drive_master(m, 1'b1, 1'b1, req_we[m][0], req_addr[m][0], req_data[m][0], req_sel[m][0]);
    while (done < n) begin
        @(negedge clk);
        sample_rsp(m, stall, ack, err, rdata);
        if (ack || err) begin
            if (done >= issued) begin
                fail_now($sformatf("Master %0d got a response with no request open", m));
            end
            if (ack && err) begin
                fail_now($sformatf("Master %0d saw ack and err together", m));
            end
            rsp_ack[m][done] = ack;
            rsp_err[m][done] = err;
            rsp_data[m][done] = rdata;
            rsp_cyc[m][done] = cycle_count;
            if (cycle_count - acc_cyc[m][done] != 2) begin
                fail_now($sformatf("Master %0d response %0d came %0d cycles after acceptance",
                                   m, done, cycle_count - acc_cyc[m][done]));
            end
            done++;
        end
        accept = (issued < n) && !stall;
        if (accept) begin
            acc_cyc[m][issued] = cycle_count;
            stall_run = 0;
        end else if (issued < n) begin
            stall_run++;
            if (stall_run > STALL_LIMIT) begin
                fail_now($sformatf("Master %0d stayed stalled for more than %0d cycles",
                                   m, STALL_LIMIT));
            end
        end
        @(posedge clk);
        #1;
        if (accept) begin
            issued++;
        end
        if (issued < n) begin
            drive_master(m, 1'b1, 1'b1, req_we[m][issued], req_addr[m][issued],
                         req_data[m][issued], req_sel[m][issued]);
        end else if (done < n) begin
            drive_master(m, 1'b1, 1'b0, 1'b0, '0, '0, '0);
        end else begin
            drive_master(m, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        end
    end
endtask

task automatic write_word(input int m, input wb_soc_pkg::wb_addr_t addr,
                          input wb_soc_pkg::wb_data_t data, input wb_soc_pkg::wb_sel_t sel);
    req_we[m][0] = 1'b1;
    req_addr[m][0] = addr;
    req_data[m][0] = data;
    req_sel[m][0] = sel;
    run_bus(m, 1);
    check_flag((m == 0) ? "o_a_ack" : "o_b_ack", rsp_ack[m][0], 1'b1);
endtask

task automatic read_word(input int m, input wb_soc_pkg::wb_addr_t addr,
                         output wb_soc_pkg::wb_data_t data, output logic err);
    req_we[m][0] = 1'b0;
    req_addr[m][0] = addr;
    req_data[m][0] = '0;
    req_sel[m][0] = 4'hF;
    run_bus(m, 1);
    data = rsp_data[m][0];
    err = rsp_err[m][0];
endtask

// Caller fills req_addr before the burst
task automatic read_burst(input int m, input int n);
    for (int i = 0; i < n; i++) begin
        req_we[m][i] = 1'b0;
        req_data[m][i] = '0;
        req_sel[m][i] = 4'hF;
    end
    run_bus(m, n);
endtask

task automatic test_reset_state();
    @(negedge clk);
    check_io("o_leds", leds, 16'h0000);
    check_flag("o_a_ack", a_ack, 1'b0);
    check_flag("o_a_err", a_err, 1'b0);
    check_flag("o_b_ack", b_ack, 1'b0);
    check_flag("o_b_err", b_err, 1'b0);
    check_flag("o_a_stall", a_stall, 1'b1);
    check_flag("o_b_stall", b_stall, 1'b1);
endtask

task automatic test_ram_rw();
    wb_soc_pkg::wb_data_t wdata;
    wb_soc_pkg::wb_data_t pdata;
    wb_soc_pkg::wb_data_t rdata;
    wb_soc_pkg::wb_sel_t sel;
    logic err;
    for (int i = 0; i < 4; i++) begin
        test_addr[i] = wb_soc_pkg::wb_addr_t'($random(seed) & 32'h3FF);
        wdata = $random(seed);
        write_word(0, test_addr[i], wdata, 4'hF);
        ram_model[test_addr[i][9:0]] = wdata;
        pdata = $random(seed);
        sel = wb_soc_pkg::wb_sel_t'($random(seed));
        // Keep the second write partial
        if (sel == 4'h0 || sel == 4'hF) begin
            sel = 4'b0101;
        end
        write_word(0, test_addr[i], pdata, sel);
        ram_model[test_addr[i][9:0]] = merge_bytes(ram_model[test_addr[i][9:0]], pdata, sel);
        read_word(0, test_addr[i], rdata, err);
        check_flag("o_a_err", err, 1'b0);
        check_data("o_a_rdata", rdata, ram_model[test_addr[i][9:0]]);
    end
endtask

task automatic test_pipelined_reads();
    for (int i = 0; i < 4; i++) begin
        req_addr[1][i] = test_addr[i];
    end
    read_burst(1, 4);
    for (int i = 0; i < 4; i++) begin
        check_flag("o_b_ack", rsp_ack[1][i], 1'b1);
        check_data("o_b_rdata", rsp_data[1][i], ram_model[test_addr[i][9:0]]);
        if (acc_cyc[1][i] != acc_cyc[1][0] + i) begin
            fail_now("Master B reads were not accepted back to back");
        end
    end
endtask

task automatic test_switch_led();
    wb_soc_pkg::wb_data_t rdata;
    logic err;
    write_word(0, wb_soc_pkg::SWLED_ADDR, 32'h0000_1234, 4'b0011);
    check_io("o_leds", leds, 16'h1234);
    // Only the low byte may change
    write_word(0, wb_soc_pkg::SWLED_ADDR, 32'h0000_C3AB, 4'b0001);
    check_io("o_leds", leds, 16'h12AB);
    read_word(0, wb_soc_pkg::SWLED_ADDR, rdata, err);
    check_flag("o_a_err", err, 1'b0);
    check_data("o_a_rdata", rdata, {16'h12AB, switches});
endtask

task automatic test_timer();
    wb_soc_pkg::wb_addr_t limit_addr;
    wb_soc_pkg::wb_data_t rdata;
    logic err;
    int w_acc;
    int elapsed;
    limit_addr = wb_soc_pkg::TIMER_BASE + 30'd1;
    write_word(0, limit_addr, 32'h0012_3456, 4'hF);
    read_word(0, limit_addr, rdata, err);
    check_flag("o_a_err", err, 1'b0);
    check_data("o_a_rdata", rdata, 32'h0012_3456);
    write_word(0, wb_soc_pkg::TIMER_BASE, 32'h0000_0100, 4'hF);
    w_acc = acc_cyc[0][0];
    repeat (10) @(posedge clk);
    read_word(0, wb_soc_pkg::TIMER_BASE, rdata, err);
    check_flag("o_a_err", err, 1'b0);
    elapsed = acc_cyc[0][0] - w_acc;
    if (rdata <= 32'h100 || rdata > 32'h100 + elapsed) begin
        fail_now($sformatf("mismatch o_a_rdata got 0x%h expected above 0x100 and at most 0x%h",
                           rdata, 32'h100 + elapsed));
    end
    // Small wrap limit with the count restarted below it
    write_word(0, limit_addr, 32'd3, 4'hF);
    write_word(0, wb_soc_pkg::TIMER_BASE, 32'd0, 4'hF);
    for (int i = 0; i < 6; i++) begin
        req_addr[0][i] = wb_soc_pkg::TIMER_BASE;
    end
    read_burst(0, 6);
    for (int i = 0; i < 6; i++) begin
        check_flag("o_a_ack", rsp_ack[0][i], 1'b1);
        if (rsp_data[0][i] > 32'd3) begin
            fail_now($sformatf("mismatch o_a_rdata got 0x%h expected at most 0x3",
                               rsp_data[0][i]));
        end
    end
endtask

task automatic test_error_response();
    wb_soc_pkg::wb_data_t rdata;
    logic err;
    read_word(0, 30'h0400010, rdata, err);
    check_flag("o_a_err", err, 1'b1);
    check_flag("o_a_ack", rsp_ack[0][0], 1'b0);
    read_word(0, test_addr[0], rdata, err);
    check_flag("o_a_err", err, 1'b0);
    check_flag("o_a_ack", rsp_ack[0][0], 1'b1);
    check_data("o_a_rdata", rdata, ram_model[test_addr[0][9:0]]);
endtask

task automatic test_priority();
    for (int i = 0; i < 3; i++) begin
        req_addr[0][i] = test_addr[i];
    end
    for (int i = 0; i < 2; i++) begin
        req_addr[1][i] = test_addr[3-i];
    end
    fork
        read_burst(0, 3);
        read_burst(1, 2);
    join
    if (acc_cyc[1][0] <= rsp_cyc[0][2]) begin
        fail_now("Master B was accepted before master A finished");
    end
    for (int i = 0; i < 3; i++) begin
        check_flag("o_a_ack", rsp_ack[0][i], 1'b1);
        check_data("o_a_rdata", rsp_data[0][i], ram_model[test_addr[i][9:0]]);
    end
    for (int i = 0; i < 2; i++) begin
        check_flag("o_b_ack", rsp_ack[1][i], 1'b1);
        check_data("o_b_rdata", rsp_data[1][i], ram_model[test_addr[3-i][9:0]]);
    end
endtask

`endif

// ==== verif/tb_wb_soc.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_wb_soc;

    localparam int MAX_REQ = 8;
    // About 40 bus transactions of well under 20 cycles each, plus idle waits
    localparam int MAX_CYCLES = 2000;
    localparam int STALL_LIMIT = 20;

    logic                 clk;
    logic                 rst_n;

    // Master A
    logic                 a_cyc;
    logic                 a_stb;
    logic                 a_we;
    wb_soc_pkg::wb_addr_t a_addr;
    wb_soc_pkg::wb_data_t a_data;
    wb_soc_pkg::wb_sel_t  a_sel;
    logic                 a_stall;
    logic                 a_ack;
    logic                 a_err;
    wb_soc_pkg::wb_data_t a_rdata;

    // Master B
    logic                 b_cyc;
    logic                 b_stb;
    logic                 b_we;
    wb_soc_pkg::wb_addr_t b_addr;
    wb_soc_pkg::wb_data_t b_data;
    wb_soc_pkg::wb_sel_t  b_sel;
    logic                 b_stall;
    logic                 b_ack;
    logic                 b_err;
    wb_soc_pkg::wb_data_t b_rdata;

    wb_soc_pkg::io_vec_t  leds;
    wb_soc_pkg::io_vec_t  switches;

    // Per master request list and response record, row 0 is A and row 1 is B
    logic                 req_we   [2][MAX_REQ];
    wb_soc_pkg::wb_addr_t req_addr [2][MAX_REQ];
    wb_soc_pkg::wb_data_t req_data [2][MAX_REQ];
    wb_soc_pkg::wb_sel_t  req_sel  [2][MAX_REQ];
    wb_soc_pkg::wb_data_t rsp_data [2][MAX_REQ];
    logic                 rsp_ack  [2][MAX_REQ];
    logic                 rsp_err  [2][MAX_REQ];
    int                   acc_cyc  [2][MAX_REQ];
    int                   rsp_cyc  [2][MAX_REQ];

    // Expected RAM contents
    wb_soc_pkg::wb_data_t ram_model [1024];
    wb_soc_pkg::wb_addr_t test_addr [4];

    int cycle_count = 0;
    int seed;

    wb_soc_fabric dut_i (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_a_cyc    (a_cyc),
        .i_a_stb    (a_stb),
        .i_a_we     (a_we),
        .i_a_addr   (a_addr),
        .i_a_data   (a_data),
        .i_a_sel    (a_sel),
        .o_a_stall  (a_stall),
        .o_a_ack    (a_ack),
        .o_a_err    (a_err),
        .o_a_rdata  (a_rdata),
        .i_b_cyc    (b_cyc),
        .i_b_stb    (b_stb),
        .i_b_we     (b_we),
        .i_b_addr   (b_addr),
        .i_b_data   (b_data),
        .i_b_sel    (b_sel),
        .o_b_stall  (b_stall),
        .o_b_ack    (b_ack),
        .o_b_err    (b_err),
        .o_b_rdata  (b_rdata),
        .o_leds     (leds),
        .i_switches (switches)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            fail_now($sformatf("Timeout, the run passed %0d cycles", MAX_CYCLES));
        end
    end

    `include "tb_wb_soc_tasks.svh"

    initial begin
        seed = 35;
        rst_n = 1'b0;
        switches = 16'hA5C3;
        drive_master(0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_master(1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_ram_rw();
        test_pipelined_reads();
        test_switch_led();
        test_timer();
        test_error_response();
        test_priority();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verif
hdl/wb_soc_pkg.sv
hdl/wb_pri_arbiter.sv
hdl/wb_addr_decode.sv
hdl/wb_ram.sv
hdl/wb_switch_led.sv
hdl/wb_timer.sv
hdl/wb_soc_fabric.sv
verif/tb_wb_soc.sv

// ==== Makefile ====
TOP = tb_wb_soc

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): compile.f $(wildcard hdl/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
	verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f compile.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
